/* Makefile */
# Verilator build and run for the timed command sequencer

VERILATOR ?= verilator
TOP       ?= tb_time_sequencer
RTL_TOP   ?= time_sequencer_top
FILELIST  ?= time_sequencer.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(wildcard *.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qF '** PASS **' $(LOG) || (echo "simulation did not pass"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bus_pkg.sv */
package bus_pkg;

  // register bus between the scheduler and the pulse units
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;

  // high byte of an address picks the unit and the low byte picks the register
  localparam int UNIT_W = 8;
  localparam int REG_W  = 8;

  // bank size and the index width needed to reach every unit
  localparam int NUM_UNITS  = 4;
  localparam int UNIT_IDX_W = (NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1;

  // register offsets inside one unit
  localparam logic [REG_W-1:0] REG_CTRL = 8'h00;
  // busy reg reads the remaining pulse count and reads zero when idle
  localparam logic [REG_W-1:0] REG_BUSY = 8'h0A;

  // pulse length comes from the low bits of the written data
  localparam int PULSE_W = 16;

endpackage

/* cmd_decode.sv */
`timescale 1ns/1ps

module cmd_decode (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          load,
  input  sched_pkg::cmd_word_t          cmd,
  output logic [sched_pkg::TIME_W-1:0]  cmd_time,
  output logic [bus_pkg::ADDR_W-1:0]    cmd_addr,
  output logic [bus_pkg::DATA_W-1:0]    cmd_data,
  output logic [bus_pkg::ADDR_W-1:0]    busy_addr,
  output logic                          immediate,
  output logic                          unit_ok
);

  import sched_pkg::*;
  import bus_pkg::*;

  cmd_word_t cmd_q;

  // command register, loaded once per fetched word
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cmd_q <= '0;
    end else if (load) begin
      cmd_q <= cmd;
    end
  end

  // plain field split of the held command
  assign cmd_time = cmd_q.exec_time;
  assign cmd_addr = cmd_q.addr;
  assign cmd_data = cmd_q.data;

  // poll target keeps the unit byte and swaps in the busy register offset
  assign busy_addr = {cmd_q.addr[ADDR_W-1 -: UNIT_W], REG_BUSY};

  // zero time skips the wait on the time counter
  assign immediate = (cmd_q.exec_time == '0);

  // unit check looks at the fifo word directly so it is ready in the load cycle
  // the fifo output does not move until the next pop
  assign unit_ok = (cmd.addr[ADDR_W-1 -: UNIT_W] < UNIT_W'(NUM_UNITS));

endmodule

/* event_log.sv */
`timescale 1ns/1ps

module event_log (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          wr,
  input  logic [sched_pkg::TIME_W-1:0]  issue_time,
  input  logic [bus_pkg::ADDR_W-1:0]    addr,
  input  logic [bus_pkg::DATA_W-1:0]    data,
  input  logic                          log_rd_en,
  output sched_pkg::log_entry_t         log_dout,
  output logic                          log_valid,
  output logic                          log_empty
);

  import sched_pkg::*;

  log_entry_t entry;
  logic       log_full;
  logic       push;

  // one entry per bus write stamped with the cycle it went out
  always_comb begin
    entry.issue_time = issue_time;
    entry.addr       = addr;
    entry.data       = data;
  end

  // entries are lost when the host falls behind
  assign push = wr && !log_full;

  sync_fifo #(
    .T     (log_entry_t),
    .DEPTH (LOG_FIFO_DEPTH)
  ) u_log_fifo (
    .clk   (clk),
    .rst   (rst),
    .wr_en (push),
    .din   (entry),
    .full  (log_full),
    .rd_en (log_rd_en),
    .dout  (log_dout),
    .valid (log_valid),
    .empty (log_empty)
  );

endmodule

/* pin_bank.sv */
`timescale 1ns/1ps

module pin_bank (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [bus_pkg::ADDR_W-1:0]    bus_addr,
  input  logic [bus_pkg::DATA_W-1:0]    bus_data,
  input  logic                          bus_en,
  input  logic                          bus_re,
  input  logic                          bus_wr,
  output logic [bus_pkg::DATA_W-1:0]    bus_rdata,
  output logic [bus_pkg::NUM_UNITS-1:0] pins
);

  import bus_pkg::*;

  logic [UNIT_W-1:0]  unit_sel;
  logic [REG_W-1:0]   reg_sel;
  logic               unit_hit;
  logic [PULSE_W-1:0] pulse_cnt [NUM_UNITS];

  // address decode shared by all units
  assign unit_sel = bus_addr[ADDR_W-1 -: UNIT_W];
  assign reg_sel  = bus_addr[REG_W-1:0];
  assign unit_hit = (unit_sel < UNIT_W'(NUM_UNITS));

  for (genvar u = 0; u < NUM_UNITS; u++) begin : g_unit
    logic ctrl_wr;

    assign ctrl_wr = bus_en && bus_wr && (unit_sel == UNIT_W'(u)) && (reg_sel == REG_CTRL);

    // down-counter loaded with the pulse length on a ctrl write
    // a length of zero leaves the pin low
    always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
        pulse_cnt[u] <= '0;
      end else if (ctrl_wr) begin
        pulse_cnt[u] <= bus_data[PULSE_W-1:0];
      end else if (pulse_cnt[u] != '0) begin
        pulse_cnt[u] <= pulse_cnt[u] - 1'b1;
      end
    end

    // pin follows the counter and stays high for exactly the loaded count
    assign pins[u] = (pulse_cnt[u] != '0);
  end

  // read mux returns data in the same cycle
  // only the busy register is readable and everything else reads zero
  always_comb begin
    bus_rdata = '0;
    if (bus_en && bus_re && unit_hit && (reg_sel == REG_BUSY)) begin
      bus_rdata = DATA_W'(pulse_cnt[unit_sel[UNIT_IDX_W-1:0]]);
    end
  end

endmodule

/* sched_pkg.sv */
package sched_pkg;

  import bus_pkg::*;

  // width of the free-running time counter
  localparam int TIME_W = 32;

  // queue depths on the host side
  localparam int CMD_FIFO_DEPTH = 16;
  localparam int LOG_FIFO_DEPTH = 16;

  // command word of 80 bits with time, data and address from the msb down
  // a time of zero means run as soon as the unit is free
  typedef struct packed {
    logic [TIME_W-1:0] exec_time;
    logic [DATA_W-1:0] data;
    logic [ADDR_W-1:0] addr;
  } cmd_word_t;

  // log entry of 80 bits with issue time, address and data from the msb down
  typedef struct packed {
    logic [TIME_W-1:0] issue_time;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } log_entry_t;

endpackage

/* sched_tests.mem */
// columns (hex): test number _ execution time _ data _ address
// address high byte is the unit, low byte the register; test 00 ends the list
01_00000000_00000005_0000
01_00000000_00000003_0100
01_00000000_00000000_0200
01_00000000_00000007_0300
02_00000000_00000006_0200
02_00000100_00000004_0000
02_00000140_00000009_0300
03_00000000_00000020_0100
03_00000000_00000010_0100
03_00000000_00000003_0100
04_00000000_00000008_0400
04_00000000_00000002_0000
04_00000000_00000005_7f00
04_00000200_00000003_1000
04_00000000_00000009_0205
04_00000000_00000001_0300

/* scheduler.sv */
`timescale 1ns/1ps

module scheduler (
  input  logic                          clk,
  input  logic                          rst,
  // command fifo side
  input  logic                          cmd_empty,
  input  logic                          cmd_valid,
  output logic                          cmd_rd_en,
  // decode side
  output logic                          load,
  input  logic [sched_pkg::TIME_W-1:0]  cmd_time,
  input  logic [bus_pkg::ADDR_W-1:0]    cmd_addr,
  input  logic [bus_pkg::DATA_W-1:0]    cmd_data,
  input  logic [bus_pkg::ADDR_W-1:0]    busy_addr,
  input  logic                          immediate,
  input  logic                          unit_ok,
  // time base
  output logic [sched_pkg::TIME_W-1:0]  current_time,
  // register bus master
  output logic [bus_pkg::ADDR_W-1:0]    bus_addr,
  output logic [bus_pkg::DATA_W-1:0]    bus_data,
  output logic                          bus_en,
  output logic                          bus_re,
  output logic                          bus_wr,
  input  logic [bus_pkg::DATA_W-1:0]    bus_rdata
);

  // one-hot encoding
  typedef enum logic [5:0] {
    exec_wait = 6'b000001,
    fetch     = 6'b000010,
    fifo_wait = 6'b000100,
    exec      = 6'b001000,
    idle      = 6'b010000,
    bus_wait  = 6'b100000
  } state_t;

  state_t state;
  state_t next_state;
  logic   time_reached;

  // free-running time base that starts at zero after reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      current_time <= '0;
    end else begin
      current_time <= current_time + 1'b1;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  assign time_reached = immediate || (current_time >= cmd_time);

  // next state and bus strobes are all combinational
  always_comb begin
    next_state = state;
    cmd_rd_en  = 1'b0;
    load       = 1'b0;
    bus_en     = 1'b0;
    bus_re     = 1'b0;
    bus_wr     = 1'b0;
    bus_addr   = cmd_addr;
    bus_data   = cmd_data;
    unique case (state)
      idle: begin
        next_state = fetch;
      end
      fetch: begin
        // pop one word when there is one
        if (!cmd_empty) begin
          cmd_rd_en  = 1'b1;
          next_state = fifo_wait;
        end
      end
      fifo_wait: begin
        // word shows up one cycle after the pop
        if (cmd_valid) begin
          load       = 1'b1;
          // an unknown unit is dropped without touching the bus
          next_state = unit_ok ? bus_wait : fetch;
        end
      end
      bus_wait: begin
        // keep reading the busy register until the unit is free
        bus_en   = 1'b1;
        bus_re   = 1'b1;
        bus_addr = busy_addr;
        if (bus_rdata == '0) begin
          next_state = exec;
        end
      end
      exec: begin
        // single-cycle write once the time has come
        if (time_reached) begin
          bus_en     = 1'b1;
          bus_wr     = 1'b1;
          next_state = exec_wait;
        end
      end
      exec_wait: begin
        // one quiet cycle so the unit can pick up the write
        next_state = fetch;
      end
      default: begin
        next_state = idle;
      end
    endcase
  end

endmodule

/* sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 16
) (
  input  logic clk,
  input  logic rst,
  input  logic wr_en,
  input  T     din,
  output logic full,
  input  logic rd_en,
  output T     dout,
  output logic valid,
  output logic empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);

  // requests against a full or empty queue are simply dropped
  assign push = wr_en && !full;
  assign pop  = rd_en && !empty;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      valid  <= 1'b0;
    end else begin
      // valid marks the cycle the popped word sits on dout
      valid <= pop;
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage write and registered read port
  // dout holds its word until the next pop
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
    if (pop) begin
      dout <= mem[rd_ptr];
    end
  end

endmodule

/* tb_time_sequencer.sv */
`timescale 1ns/1ps

module tb_time_sequencer;

  import sched_pkg::*;
  import bus_pkg::*;

  localparam int MAX_LINES = 64;

  logic                 clk;
  logic                 rst;
  logic                 cmd_wr_en;
  cmd_word_t            cmd_din;
  logic                 cmd_full;
  logic                 log_rd_en;
  log_entry_t           log_dout;
  logic                 log_valid;
  logic                 log_empty;
  logic [TIME_W-1:0]    current_time;
  logic [NUM_UNITS-1:0] pins;

  // one line per command with the test number in the top byte and the command below
  logic [87:0]  tests [MAX_LINES];
  cmd_word_t    test_cmds [MAX_LINES];
  cmd_word_t    exp_cmds [MAX_LINES];
  logic [31:0]  exp_later [MAX_LINES];
  int           exp_w [NUM_UNITS][MAX_LINES];
  int           n_wexp [NUM_UNITS];
  int           base_seen [NUM_UNITS];
  logic         prev_ok [NUM_UNITS];
  logic [31:0]  prev_end [NUM_UNITS];
  // pulse widths seen on the pins as filled in by the monitor
  int           seen_w [NUM_UNITS][MAX_LINES];
  int           seen_n [NUM_UNITS];
  int           high_cnt [NUM_UNITS];

  int           seed;
  int           errors = 0;
  int           checks = 0;
  int           cycles = 0;
  int           limit = 1000000;
  int           line;
  int           n_cmd;
  int           n_exp;
  int           unit;
  int           test_id;
  int           err_before;
  int           tests_run;
  int           tests_bad;
  logic [31:0]  later;
  log_entry_t   entry;

  time_sequencer_top DUT (
    .clk          (clk),
    .rst          (rst),
    .cmd_wr_en    (cmd_wr_en),
    .cmd_din      (cmd_din),
    .cmd_full     (cmd_full),
    .log_rd_en    (log_rd_en),
    .log_dout     (log_dout),
    .log_valid    (log_valid),
    .log_empty    (log_empty),
    .current_time (current_time),
    .pins         (pins)
  );

  always #4 clk = ~clk;

  // run limit is worked out from the test file before reset ends
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  // pin monitor counts high cycles and records each finished pulse
  always @(negedge clk) begin
    for (int u = 0; u < NUM_UNITS; u++) begin
      if (rst) begin
        high_cnt[u] <= 0;
        seen_n[u]   <= 0;
      end else if (pins[u]) begin
        high_cnt[u] <= high_cnt[u] + 1;
      end else if (high_cnt[u] != 0 && seen_n[u] < MAX_LINES) begin
        seen_w[u][seen_n[u]] <= high_cnt[u];
        seen_n[u]            <= seen_n[u] + 1;
        high_cnt[u]          <= 0;
      end
    end
  end

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act) begin
      $display("mismatch %s expected %0h actual %0h", name, exp, act);
      errors++;
    end
  endtask

  // host push holds off while the queue is full
  task automatic push_cmd(input cmd_word_t c);
    while (cmd_full) @(negedge clk);
    cmd_wr_en = 1'b1;
    cmd_din   = c;
    @(negedge clk);
    cmd_wr_en = 1'b0;
  endtask

  // random gap and then one pop
  // the entry shows up a cycle later
  task automatic read_log(output log_entry_t e);
    int gap;
    gap = $random(seed) & 3;
    repeat (gap) @(negedge clk);
    while (log_empty) @(negedge clk);
    log_rd_en = 1'b1;
    @(negedge clk);
    log_rd_en = 1'b0;
    if (!log_valid) begin
      $display("log_valid did not follow a log read");
      errors++;
    end
    e = log_dout;
  endtask

  initial begin
    seed      = 32'h4e5729c4;
    clk       = 1'b0;
    rst       = 1'b1;
    cmd_wr_en = 1'b0;
    cmd_din   = '0;
    log_rd_en = 1'b0;
    tests_run = 0;
    tests_bad = 0;
    for (int i = 0; i < MAX_LINES; i++) tests[i] = '0;
    $readmemh("sched_tests.mem", tests);
    // bound from the latest command time, all pulses and 20 cycles per command
    later = 0;
    limit = 100;
    for (int i = 0; i < MAX_LINES && tests[i][87:80] != 0; i++) begin
      limit += 20 + int'(tests[i][31:16]);
      if (tests[i][79:48] > later) later = tests[i][79:48];
    end
    limit += int'(later);
    for (int u = 0; u < NUM_UNITS; u++) prev_ok[u] = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // state right after reset with the time base starting at zero
    check("reset pins", 0, pins);
    check("reset log_empty", 1, log_empty);
    check("reset cmd_full", 0, cmd_full);
    check("reset current_time", 0, current_time);
    @(negedge clk);
    check("current_time after one cycle", 1, current_time);
    @(negedge clk);
    check("current_time after two cycles", 2, current_time);
    $display("reset: %0d errors", errors);
    line = 0;
    while (line < MAX_LINES && tests[line][87:80] != 0) begin
      test_id    = tests[line][87:80];
      err_before = errors;
      n_cmd      = 0;
      while (line < MAX_LINES && tests[line][87:80] == test_id) begin
        test_cmds[n_cmd] = tests[line][79:0];
        n_cmd++;
        line++;
      end
      // reference model drops unknown units, keeps the order and notes the pulses
      n_exp = 0;
      for (int u = 0; u < NUM_UNITS; u++) begin
        n_wexp[u]    = 0;
        base_seen[u] = seen_n[u];
      end
      for (int i = 0; i < n_cmd; i++) begin
        unit = test_cmds[i].addr[15:8];
        if (unit < NUM_UNITS) begin
          // earliest time of any later valid timed command
          later = '1;
          for (int j = i + 1; j < n_cmd; j++) begin
            if (test_cmds[j].addr[15:8] < NUM_UNITS && test_cmds[j].exec_time != 0 &&
                test_cmds[j].exec_time < later) later = test_cmds[j].exec_time;
          end
          exp_cmds[n_exp]  = test_cmds[i];
          exp_later[n_exp] = later;
          n_exp++;
          if (test_cmds[i].addr[7:0] == REG_CTRL && test_cmds[i].data[PULSE_W-1:0] != 0) begin
            exp_w[unit][n_wexp[unit]] = test_cmds[i].data[PULSE_W-1:0];
            n_wexp[unit]++;
          end
        end
      end
      for (int i = 0; i < n_cmd; i++) push_cmd(test_cmds[i]);
      for (int k = 0; k < n_exp; k++) begin
        read_log(entry);
        unit = exp_cmds[k].addr[15:8];
        check($sformatf("test %0d entry %0d addr", test_id, k), exp_cmds[k].addr, entry.addr);
        check($sformatf("test %0d entry %0d data", test_id, k), exp_cmds[k].data, entry.data);
        if (entry.issue_time < exp_cmds[k].exec_time) begin
          $display("test %0d entry %0d was issued at %0d, before its time %0d",
                   test_id, k, entry.issue_time, exp_cmds[k].exec_time);
          errors++;
        end
        if (exp_cmds[k].exec_time == 0 && entry.issue_time >= exp_later[k]) begin
          $display("test %0d entry %0d has time zero but waited until %0d",
                   test_id, k, entry.issue_time);
          errors++;
        end
        if (prev_ok[unit] && entry.issue_time < prev_end[unit]) begin
          $display("test %0d entry %0d was issued at %0d while unit %0d was busy until %0d",
                   test_id, k, entry.issue_time, unit, prev_end[unit]);
          errors++;
        end
        if (exp_cmds[k].addr[7:0] == REG_CTRL) begin
          prev_ok[unit]  = 1'b1;
          prev_end[unit] = entry.issue_time + exp_cmds[k].data[PULSE_W-1:0];
        end
      end
      // let the last pulse end before counting
      while (pins != '0) @(negedge clk);
      @(negedge clk);
      for (int u = 0; u < NUM_UNITS; u++) begin
        check($sformatf("test %0d unit %0d pulse count", test_id, u),
              n_wexp[u], seen_n[u] - base_seen[u]);
        for (int k = 0; k < n_wexp[u] && base_seen[u] + k < seen_n[u]; k++) begin
          check($sformatf("test %0d unit %0d pulse %0d width", test_id, u, k),
                exp_w[u][k], seen_w[u][base_seen[u] + k]);
        end
      end
      // nothing beyond the valid commands may reach the log
      check($sformatf("test %0d log empty at end", test_id), 1, log_empty);
      tests_run++;
      if (errors != err_before) tests_bad++;
      $display("test %0d: %0d commands, %0d logged, %0d errors",
               test_id, n_cmd, n_exp, errors - err_before);
    end
    if (tests_run == 0) begin
      $display("no tests were read from sched_tests.mem");
      errors++;
    end
    $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
             tests_run, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* time_sequencer.f */
bus_pkg.sv
sched_pkg.sv
sync_fifo.sv
cmd_decode.sv
scheduler.sv
event_log.sv
pin_bank.sv
time_sequencer_top.sv
tb_time_sequencer.sv

/* time_sequencer_top.sv */
`timescale 1ns/1ps

module time_sequencer_top (
  input  logic                          clk,
  input  logic                          rst,
  // host command path
  input  logic                          cmd_wr_en,
  input  sched_pkg::cmd_word_t          cmd_din,
  output logic                          cmd_full,
  // host log path
  input  logic                          log_rd_en,
  output sched_pkg::log_entry_t         log_dout,
  output logic                          log_valid,
  output logic                          log_empty,
  // status and unit outputs
  output logic [sched_pkg::TIME_W-1:0]  current_time,
  output logic [bus_pkg::NUM_UNITS-1:0] pins
);

  import sched_pkg::*;
  import bus_pkg::*;

  // fifo to scheduler and decode
  cmd_word_t         cmd_dout;
  logic              cmd_empty;
  logic              cmd_valid;
  logic              cmd_rd_en;
  logic              load;

  // decoded fields
  logic [TIME_W-1:0] cmd_time;
  logic [ADDR_W-1:0] cmd_addr;
  logic [DATA_W-1:0] cmd_data;
  logic [ADDR_W-1:0] busy_addr;
  logic              immediate;
  logic              unit_ok;

  // register bus
  logic [ADDR_W-1:0] bus_addr;
  logic [DATA_W-1:0] bus_data;
  logic [DATA_W-1:0] bus_rdata;
  logic              bus_en;
  logic              bus_re;
  logic              bus_wr;

  sync_fifo #(
    .T     (cmd_word_t),
    .DEPTH (CMD_FIFO_DEPTH)
  ) u_cmd_fifo (
    .clk   (clk),
    .rst   (rst),
    .wr_en (cmd_wr_en),
    .din   (cmd_din),
    .full  (cmd_full),
    .rd_en (cmd_rd_en),
    .dout  (cmd_dout),
    .valid (cmd_valid),
    .empty (cmd_empty)
  );

  cmd_decode u_decode (
    .clk       (clk),
    .rst       (rst),
    .load      (load),
    .cmd       (cmd_dout),
    .cmd_time  (cmd_time),
    .cmd_addr  (cmd_addr),
    .cmd_data  (cmd_data),
    .busy_addr (busy_addr),
    .immediate (immediate),
    .unit_ok   (unit_ok)
  );

  scheduler u_sched (
    .clk          (clk),
    .rst          (rst),
    .cmd_empty    (cmd_empty),
    .cmd_valid    (cmd_valid),
    .cmd_rd_en    (cmd_rd_en),
    .load         (load),
    .cmd_time     (cmd_time),
    .cmd_addr     (cmd_addr),
    .cmd_data     (cmd_data),
    .busy_addr    (busy_addr),
    .immediate    (immediate),
    .unit_ok      (unit_ok),
    .current_time (current_time),
    .bus_addr     (bus_addr),
    .bus_data     (bus_data),
    .bus_en       (bus_en),
    .bus_re       (bus_re),
    .bus_wr       (bus_wr),
    .bus_rdata    (bus_rdata)
  );

  // the write strobe doubles as the log push
  event_log u_log (
    .clk        (clk),
    .rst        (rst),
    .wr         (bus_wr),
    .issue_time (current_time),
    .addr       (bus_addr),
    .data       (bus_data),
    .log_rd_en  (log_rd_en),
    .log_dout   (log_dout),
    .log_valid  (log_valid),
    .log_empty  (log_empty)
  );

  pin_bank u_pins (
    .clk       (clk),
    .rst       (rst),
    .bus_addr  (bus_addr),
    .bus_data  (bus_data),
    .bus_en    (bus_en),
    .bus_re    (bus_re),
    .bus_wr    (bus_wr),
    .bus_rdata (bus_rdata),
    .pins      (pins)
  );

endmodule
